//--- include/ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data path width
`define EX_XLEN 32

// Unit-select vector bit positions
`define EX_UNIT_ALU 0
`define EX_UNIT_MDU 1
`define EX_UNIT_LSU 2

// Forwarding vector bit positions
`define EX_FWD_OP1_EXMA 0
`define EX_FWD_OP2_EXMA 1
`define EX_FWD_OP1_MAWB 2
`define EX_FWD_OP2_MAWB 3

// Multiplier bits consumed per cycle (1, 2, 4 or 8)
`define EX_MUL_STEP 2

`endif

//--- src/ex_pkg.sv
`default_nettype none
`include "ex_macros.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] word_t;    // Operand or result word
    typedef logic [4:0]          rf_add_t;  // Register-file address
    typedef logic [2:0]          unit_t;    // One-hot unit select where zero is a NOP
    typedef logic [3:0]          fwd_t;     // Forwarding select

    // Function code interpreted per unit
    typedef enum logic [3:0] {
        F_ADD   = 4'd0,
        F_SUB   = 4'd1,
        F_AND   = 4'd2,
        F_OR    = 4'd3,
        F_XOR   = 4'd4,
        F_SLL   = 4'd5,
        F_SRL   = 4'd6,
        F_SRA   = 4'd7,
        F_SLT   = 4'd8,
        F_SLTU  = 4'd9,
        F_MUL   = 4'd10,    // Low word of product
        F_MULHU = 4'd11,    // High word, unsigned
        F_LS_B  = 4'd12,
        F_LS_H  = 4'd13,
        F_LS_W  = 4'd14
    } func_t;

    // Instruction misconduct
    typedef enum logic [1:0] {
        IMISCON_FREE = 2'd0,
        IMISCON_MISA = 2'd1,    // Misaligned access
        IMISCON_DSCR = 2'd2     // Lanes disagree
    } imiscon_t;

    typedef enum logic [1:0] {
        MDU_IDLE = 2'd0,
        MDU_BUSY = 2'd1,
        MDU_DONE = 2'd2
    } mdu_state_t;

endpackage

`default_nettype wire

//--- src/ex_mdu.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module ex_mdu (
    input  logic          s_clk_i,
    input  logic          arst_n_i,
    input  logic          start_i,
    input  logic          stall_i,
    input  logic          flush_i,
    input  logic          high_i,
    input  ex_pkg::word_t multiplicand_i,
    input  ex_pkg::word_t multiplier_i,
    output ex_pkg::word_t product_o,
    output logic          finished_o
);
    import ex_pkg::*;

    localparam int ITER  = `EX_XLEN / `EX_MUL_STEP;
    localparam int CNT_W = $clog2(ITER);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(ITER - 1);

    mdu_state_t              s_state_q, s_state_d;
    logic [CNT_W-1:0]        s_cnt_q;
    logic [2*`EX_XLEN-1:0]   s_mcand_q, s_mcand_src, s_acc_q, s_acc_src, s_partial;
    word_t                   s_mplier_q, s_mplier_src;
    logic                    s_idle, s_step;

    assign s_idle = (s_state_q == MDU_IDLE);
    // First step already happens on the start edge
    assign s_step = ~stall_i & ((s_idle & start_i) | (s_state_q == MDU_BUSY));

    // In IDLE the step works straight from the inputs
    assign s_mcand_src  = s_idle ? {{`EX_XLEN{1'b0}}, multiplicand_i} : s_mcand_q;
    assign s_mplier_src = s_idle ? multiplier_i : s_mplier_q;
    assign s_acc_src    = s_idle ? '0 : s_acc_q;

    always_comb begin
        s_partial = '0;
        for (int j = 0; j < `EX_MUL_STEP; j++) begin
            if (s_mplier_src[j]) begin
                s_partial = s_partial + (s_mcand_src << j);
            end
        end
    end

    always_comb begin
        s_state_d = s_state_q;
        case (s_state_q)
            MDU_IDLE: if (start_i & ~stall_i) s_state_d = MDU_BUSY;
            MDU_BUSY: if (~stall_i && (s_cnt_q == LAST)) s_state_d = MDU_DONE;
            MDU_DONE: if (~stall_i) s_state_d = MDU_IDLE;  // Result taken by EX/MA
            default:  s_state_d = MDU_IDLE;
        endcase
        if (flush_i) begin
            s_state_d = MDU_IDLE;   // Abandon running multiply
        end
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (~arst_n_i) begin
            s_state_q <= MDU_IDLE;
            s_cnt_q   <= '0;
        end else begin
            s_state_q <= s_state_d;
            if (s_step) begin
                s_cnt_q <= s_idle ? CNT_W'(1) : s_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (s_step) begin
            s_acc_q    <= s_acc_src + s_partial;
            s_mcand_q  <= s_mcand_src << `EX_MUL_STEP;
            s_mplier_q <= s_mplier_src >> `EX_MUL_STEP;
        end
    end

    assign product_o  = high_i ? s_acc_q[2*`EX_XLEN-1:`EX_XLEN] : s_acc_q[`EX_XLEN-1:0];
    assign finished_o = (s_state_q == MDU_DONE);

endmodule

`default_nettype wire

//--- src/ex_lane.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module ex_lane (
    input  logic           s_clk_i,
    input  logic           arst_n_i,
    input  logic           stall_i,
    input  logic           flush_i,
    input  ex_pkg::word_t  op1_i,
    input  ex_pkg::word_t  op2_i,
    input  ex_pkg::unit_t  unit_i,
    input  ex_pkg::func_t  func_i,
    input  ex_pkg::fwd_t   fwd_i,
    input  ex_pkg::word_t  exma_val_i,
    input  ex_pkg::word_t  mawb_val_i,
    output ex_pkg::word_t  operand1_o,
    output ex_pkg::word_t  operand2_o,
    output ex_pkg::word_t  result_o,
    output logic           misa_o,
    output logic           finished_o
);
    import ex_pkg::*;

    word_t                          s_operand1, s_operand2, s_alu, s_product;
    logic [$clog2(`EX_XLEN)-1:0]    s_shamt;

    // EX/MA value has priority over MA/WB
    assign s_operand1 = fwd_i[`EX_FWD_OP1_EXMA] ? exma_val_i :
                        fwd_i[`EX_FWD_OP1_MAWB] ? mawb_val_i : op1_i;
    assign s_operand2 = fwd_i[`EX_FWD_OP2_EXMA] ? exma_val_i :
                        fwd_i[`EX_FWD_OP2_MAWB] ? mawb_val_i : op2_i;

    assign s_shamt = s_operand2[$clog2(`EX_XLEN)-1:0];

    always_comb begin
        case (func_i)
            F_ADD:   s_alu = s_operand1 + s_operand2;
            F_SUB:   s_alu = s_operand1 - s_operand2;
            F_AND:   s_alu = s_operand1 & s_operand2;
            F_OR:    s_alu = s_operand1 | s_operand2;
            F_XOR:   s_alu = s_operand1 ^ s_operand2;
            F_SLL:   s_alu = s_operand1 << s_shamt;
            F_SRL:   s_alu = s_operand1 >> s_shamt;
            F_SRA:   s_alu = word_t'($signed(s_operand1) >>> s_shamt);
            F_SLT:   s_alu = word_t'($signed(s_operand1) < $signed(s_operand2));
            F_SLTU:  s_alu = word_t'(s_operand1 < s_operand2);
            default: s_alu = '0;
        endcase
    end

    ex_mdu m_mdu (
        .s_clk_i        (s_clk_i),
        .arst_n_i       (arst_n_i),
        .start_i        (unit_i[`EX_UNIT_MDU]),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .high_i         (func_i == F_MULHU),
        .multiplicand_i (s_operand1),
        .multiplier_i   (s_operand2),
        .product_o      (s_product),
        .finished_o     (finished_o)
    );

    // Halfword needs bit 0 clear, word needs bits 1:0 clear
    assign misa_o = ((func_i == F_LS_H) & s_operand1[0]) |
                    ((func_i == F_LS_W) & (|s_operand1[1:0]));

    // LSU result is the access address
    always_comb begin
        if (unit_i[`EX_UNIT_MDU]) begin
            result_o = s_product;
        end else if (unit_i[`EX_UNIT_LSU]) begin
            result_o = s_operand1;
        end else if (unit_i[`EX_UNIT_ALU]) begin
            result_o = s_alu;
        end else begin
            result_o = '0;      // Bubble
        end
    end

    assign operand1_o = s_operand1;
    assign operand2_o = s_operand2;

endmodule

`default_nettype wire

//--- src/ex_exma_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module ex_exma_reg (
    input  logic              s_clk_i,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  ex_pkg::unit_t     unit_a_i,
    input  ex_pkg::unit_t     unit_b_i,
    input  ex_pkg::func_t     func_a_i,
    input  ex_pkg::rf_add_t   rd_i,
    input  ex_pkg::word_t     result_a_i,
    input  ex_pkg::word_t     result_b_i,
    input  ex_pkg::word_t     operand1_a_i,
    input  ex_pkg::word_t     operand2_a_i,
    input  logic              misa_a_i,
    input  logic              misa_b_i,
    input  logic              fin_a_i,
    input  logic              fin_b_i,
    output logic              stall_o,
    output logic              lsu_approve_o,
    output ex_pkg::word_t     lsu_address_o,
    output ex_pkg::word_t     lsu_wdata_o,
    output ex_pkg::word_t     exma_val_o,
    output ex_pkg::rf_add_t   exma_rd_o,
    output ex_pkg::unit_t     exma_unit_o,
    output ex_pkg::func_t     exma_func_o,
    output ex_pkg::imiscon_t  exma_imiscon_o,
    output logic              exma_neq_o
);
    import ex_pkg::*;

    logic     s_neq, s_misa, s_bubble, s_clear;
    imiscon_t s_imiscon;

    // Lane comparison
    assign s_neq = (unit_a_i != unit_b_i) | (result_a_i != result_b_i);

    // Either lane reporting misalignment blocks the access
    assign s_misa = unit_a_i[`EX_UNIT_LSU] & (misa_a_i | misa_b_i);

    // Multiply in progress until a lane finishes
    assign s_bubble = unit_a_i[`EX_UNIT_MDU] & ~fin_a_i & ~fin_b_i;
    assign stall_o  = s_bubble;

    // A bubble only lands in MA when MA is not stalling
    assign s_clear = flush_i | (s_bubble & ~stall_i);

    always_comb begin
        if (s_neq) begin
            s_imiscon = IMISCON_DSCR;
        end else if (s_misa) begin
            s_imiscon = IMISCON_MISA;
        end else begin
            s_imiscon = IMISCON_FREE;
        end
    end

    assign lsu_address_o = operand1_a_i;
    assign lsu_wdata_o   = operand2_a_i;
    assign lsu_approve_o = unit_a_i[`EX_UNIT_LSU] & ~s_misa & ~s_neq & ~flush_i;

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (~arst_n_i) begin
            exma_val_o     <= '0;
            exma_rd_o      <= '0;
            exma_unit_o    <= '0;
            exma_func_o    <= F_ADD;
            exma_imiscon_o <= IMISCON_FREE;
            exma_neq_o     <= 1'b0;
        end else if (s_clear) begin
            exma_val_o     <= '0;       // NOP into MA
            exma_rd_o      <= '0;
            exma_unit_o    <= '0;
            exma_func_o    <= F_ADD;
            exma_imiscon_o <= IMISCON_FREE;
            exma_neq_o     <= 1'b0;
        end else if (~stall_i) begin
            exma_val_o     <= result_a_i;
            exma_rd_o      <= rd_i;
            exma_unit_o    <= unit_a_i;
            exma_func_o    <= func_a_i;
            exma_imiscon_o <= s_imiscon;
            exma_neq_o     <= s_neq;
        end
    end

endmodule

`default_nettype wire

//--- src/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module ex_stage (
    input  logic              s_clk_i,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  ex_pkg::word_t     op1_a_i,
    input  ex_pkg::word_t     op2_a_i,
    input  ex_pkg::unit_t     unit_a_i,
    input  ex_pkg::func_t     func_a_i,
    input  ex_pkg::fwd_t      fwd_a_i,
    input  ex_pkg::word_t     op1_b_i,
    input  ex_pkg::word_t     op2_b_i,
    input  ex_pkg::unit_t     unit_b_i,
    input  ex_pkg::func_t     func_b_i,
    input  ex_pkg::fwd_t      fwd_b_i,
    input  ex_pkg::rf_add_t   rd_i,
    input  ex_pkg::word_t     mawb_val_i,
    output logic              stall_o,
    output ex_pkg::word_t     lsu_address_o,
    output ex_pkg::word_t     lsu_wdata_o,
    output logic              lsu_approve_o,
    output ex_pkg::word_t     exma_val_o,
    output ex_pkg::rf_add_t   exma_rd_o,
    output ex_pkg::unit_t     exma_unit_o,
    output ex_pkg::func_t     exma_func_o,
    output ex_pkg::imiscon_t  exma_imiscon_o,
    output logic              exma_neq_o
);
    import ex_pkg::*;

    word_t s_result_a, s_result_b, s_operand1_a, s_operand2_a;
    logic  s_misa_a, s_misa_b, s_fin_a, s_fin_b;

    // Lane 0 on copy a
    ex_lane m_lane_a (
        .s_clk_i    (s_clk_i),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .op1_i      (op1_a_i),
        .op2_i      (op2_a_i),
        .unit_i     (unit_a_i),
        .func_i     (func_a_i),
        .fwd_i      (fwd_a_i),
        .exma_val_i (exma_val_o),
        .mawb_val_i (mawb_val_i),
        .operand1_o (s_operand1_a),
        .operand2_o (s_operand2_a),
        .result_o   (s_result_a),
        .misa_o     (s_misa_a),
        .finished_o (s_fin_a)
    );

    // Lane 1 on copy b
    // Its operands reach the comparison only through the result
    ex_lane m_lane_b (
        .s_clk_i    (s_clk_i),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .op1_i      (op1_b_i),
        .op2_i      (op2_b_i),
        .unit_i     (unit_b_i),
        .func_i     (func_b_i),
        .fwd_i      (fwd_b_i),
        .exma_val_i (exma_val_o),
        .mawb_val_i (mawb_val_i),
        .operand1_o (),
        .operand2_o (),
        .result_o   (s_result_b),
        .misa_o     (s_misa_b),
        .finished_o (s_fin_b)
    );

    ex_exma_reg m_exma_reg (
        .s_clk_i        (s_clk_i),
        .arst_n_i       (arst_n_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .unit_a_i       (unit_a_i),
        .unit_b_i       (unit_b_i),
        .func_a_i       (func_a_i),
        .rd_i           (rd_i),
        .result_a_i     (s_result_a),
        .result_b_i     (s_result_b),
        .operand1_a_i   (s_operand1_a),
        .operand2_a_i   (s_operand2_a),
        .misa_a_i       (s_misa_a),
        .misa_b_i       (s_misa_b),
        .fin_a_i        (s_fin_a),
        .fin_b_i        (s_fin_b),
        .stall_o        (stall_o),
        .lsu_approve_o  (lsu_approve_o),
        .lsu_address_o  (lsu_address_o),
        .lsu_wdata_o    (lsu_wdata_o),
        .exma_val_o     (exma_val_o),
        .exma_rd_o      (exma_rd_o),
        .exma_unit_o    (exma_unit_o),
        .exma_func_o    (exma_func_o),
        .exma_imiscon_o (exma_imiscon_o),
        .exma_neq_o     (exma_neq_o)
    );

endmodule

`default_nettype wire

//--- testbench/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "ex_macros.svh"

module ex_stage_tb;
    import ex_pkg::*;

    localparam int SEED       = 78794;
    localparam int NUM_INSTR  = 200;
    localparam int ITER       = `EX_XLEN / `EX_MUL_STEP;
    localparam int CLK_NS     = 8;
    localparam int RST_CYCLES = 16;
    localparam int LIMIT_NS   = (NUM_INSTR * (ITER + 4) + 2 * RST_CYCLES) * CLK_NS;

    logic     clk, arst_n, stall, flush;
    word_t    op1_a, op2_a, op1_b, op2_b, mawb_val;
    unit_t    unit_a, unit_b;
    func_t    func_a, func_b;
    fwd_t     fwd_a, fwd_b;
    rf_add_t  rd;

    logic     stall_o, lsu_approve_o, exma_neq_o;
    word_t    lsu_address_o, lsu_wdata_o, exma_val_o;
    rf_add_t  exma_rd_o;
    unit_t    exma_unit_o;
    func_t    exma_func_o;
    imiscon_t exma_imiscon_o;

    // Reference copy of the EX/MA register
    word_t    m_val;
    rf_add_t  m_rd;
    unit_t    m_unit;
    func_t    m_func;
    imiscon_t m_imiscon;
    logic     m_neq;

    int          mul_steps;     // Multiply iterations done so far
    word_t       mul_op1, mul_op2;  // Operands captured at the start step
    logic        seen_stall;
    int          test_errors, pass_count, fail_count;
    int unsigned seed_out;

    ex_stage uut (
        .s_clk_i        (clk),
        .arst_n_i       (arst_n),
        .stall_i        (stall),
        .flush_i        (flush),
        .op1_a_i        (op1_a),
        .op2_a_i        (op2_a),
        .unit_a_i       (unit_a),
        .func_a_i       (func_a),
        .fwd_a_i        (fwd_a),
        .op1_b_i        (op1_b),
        .op2_b_i        (op2_b),
        .unit_b_i       (unit_b),
        .func_b_i       (func_b),
        .fwd_b_i        (fwd_b),
        .rd_i           (rd),
        .mawb_val_i     (mawb_val),
        .stall_o        (stall_o),
        .lsu_address_o  (lsu_address_o),
        .lsu_wdata_o    (lsu_wdata_o),
        .lsu_approve_o  (lsu_approve_o),
        .exma_val_o     (exma_val_o),
        .exma_rd_o      (exma_rd_o),
        .exma_unit_o    (exma_unit_o),
        .exma_func_o    (exma_func_o),
        .exma_imiscon_o (exma_imiscon_o),
        .exma_neq_o     (exma_neq_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", LIMIT_NS);
        $display("sim failed");
        $finish;
    end

    // EX/MA source wins over MA/WB
    function automatic word_t pick_operand(logic exma_sel, logic mawb_sel, word_t op);
        word_t r;
        if (exma_sel) begin
            r = m_val;
        end else if (mawb_sel) begin
            r = mawb_val;
        end else begin
            r = op;
        end
        return r;
    endfunction

    function automatic word_t lane_result(unit_t unit, func_t func, word_t a, word_t b);
        logic [2*`EX_XLEN-1:0]       prod;
        logic [$clog2(`EX_XLEN)-1:0] sh;
        word_t                       r;
        prod = {{`EX_XLEN{1'b0}}, a} * {{`EX_XLEN{1'b0}}, b};
        sh   = b[$clog2(`EX_XLEN)-1:0];
        r    = '0;
        if (unit[`EX_UNIT_MDU]) begin
            r = (func == F_MULHU) ? prod[2*`EX_XLEN-1:`EX_XLEN] : prod[`EX_XLEN-1:0];
        end else if (unit[`EX_UNIT_LSU]) begin
            r = a;      // Address
        end else if (unit[`EX_UNIT_ALU]) begin
            case (func)
                F_ADD:   r = a + b;
                F_SUB:   r = a - b;
                F_AND:   r = a & b;
                F_OR:    r = a | b;
                F_XOR:   r = a ^ b;
                F_SLL:   r = a << sh;
                F_SRL:   r = a >> sh;
                F_SRA:   r = word_t'($signed(a) >>> sh);
                F_SLT:   r = ($signed(a) < $signed(b)) ? 1 : 0;
                F_SLTU:  r = (a < b) ? 1 : 0;
                default: r = '0;
            endcase
        end
        return r;
    endfunction

    function automatic logic misaligned(func_t func, word_t addr);
        return ((func == F_LS_H) && addr[0]) || ((func == F_LS_W) && (addr[1:0] != 2'b00));
    endfunction

    task automatic check_word(string name, string what, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %h actual %h", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_rd(string name, string what, rf_add_t exp, rf_add_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %0d actual %0d", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_unit(string name, string what, unit_t exp, unit_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %b actual %b", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_func(string name, string what, func_t exp, func_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %0d actual %0d", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_imiscon(string name, string what, imiscon_t exp, imiscon_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %0d actual %0d", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(string name, string what, logic exp, logic act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %b actual %b", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_exma(string name);
        check_word(name, "exma_val_o", m_val, exma_val_o);
        check_rd(name, "exma_rd_o", m_rd, exma_rd_o);
        check_unit(name, "exma_unit_o", m_unit, exma_unit_o);
        check_func(name, "exma_func_o", m_func, exma_func_o);
        check_imiscon(name, "exma_imiscon_o", m_imiscon, exma_imiscon_o);
        check_bit(name, "exma_neq_o", m_neq, exma_neq_o);
    endtask

    // One clock of the current inputs entered 1 ns after a rising edge
    task automatic run_cycle(string name);
        word_t    fa1, fa2, fb1, fb2, ra, rb;
        logic     neq, misa, exp_stall, approve;
        imiscon_t imis;
        fa1 = pick_operand(fwd_a[`EX_FWD_OP1_EXMA], fwd_a[`EX_FWD_OP1_MAWB], op1_a);
        fa2 = pick_operand(fwd_a[`EX_FWD_OP2_EXMA], fwd_a[`EX_FWD_OP2_MAWB], op2_a);
        fb1 = pick_operand(fwd_b[`EX_FWD_OP1_EXMA], fwd_b[`EX_FWD_OP1_MAWB], op1_b);
        fb2 = pick_operand(fwd_b[`EX_FWD_OP2_EXMA], fwd_b[`EX_FWD_OP2_MAWB], op2_b);
        if (mul_steps == 0) begin
            mul_op1 = fa1;
            mul_op2 = fa2;
        end
        if (unit_a[`EX_UNIT_MDU]) begin
            ra = lane_result(unit_a, func_a, mul_op1, mul_op2);
            rb = lane_result(unit_b, func_b, mul_op1, mul_op2);
        end else begin
            ra = lane_result(unit_a, func_a, fa1, fa2);
            rb = lane_result(unit_b, func_b, fb1, fb2);
        end
        neq       = (unit_a != unit_b) || (ra != rb);
        misa      = unit_a[`EX_UNIT_LSU] && (misaligned(func_a, fa1) || misaligned(func_b, fb1));
        exp_stall = unit_a[`EX_UNIT_MDU] && (mul_steps < ITER);
        approve   = unit_a[`EX_UNIT_LSU] && !misa && !neq && !flush;
        if (neq) begin
            imis = IMISCON_DSCR;
        end else if (misa) begin
            imis = IMISCON_MISA;
        end else begin
            imis = IMISCON_FREE;
        end

        #3;     // Combinational outputs settled
        seen_stall = stall_o;
        check_bit(name, "stall_o", exp_stall, stall_o);
        check_bit(name, "lsu_approve_o", approve, lsu_approve_o);
        if (unit_a[`EX_UNIT_LSU]) begin
            check_word(name, "lsu_address_o", fa1, lsu_address_o);
            check_word(name, "lsu_wdata_o", fa2, lsu_wdata_o);
        end

        if (flush || (exp_stall && !stall)) begin
            m_val     = '0;     // Bubble
            m_rd      = '0;
            m_unit    = '0;
            m_func    = F_ADD;
            m_imiscon = IMISCON_FREE;
            m_neq     = 1'b0;
        end else if (!stall) begin
            m_val     = ra;
            m_rd      = rd;
            m_unit    = unit_a;
            m_func    = func_a;
            m_imiscon = imis;
            m_neq     = neq;
        end
        if (exp_stall && !stall) begin
            mul_steps++;
        end

        @(posedge clk);
        #1;
        check_exma(name);
    endtask

    task automatic report_test(string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", name, test_errors);
        end
    endtask

    task automatic run_test(int idx);
        string name;
        int    kind;
        logic  is_mdu, done;
        kind     = $urandom_range(0, 9);
        is_mdu   = (kind == 5) || (kind == 6);
        stall    = ($urandom_range(0, 7) == 0);
        flush    = is_mdu ? 1'b0 : ($urandom_range(0, 15) == 0);
        op1_a    = $urandom;
        op2_a    = $urandom;
        fwd_a    = ($urandom_range(0, 1) == 1) ? fwd_t'($urandom) : '0;
        rd       = rf_add_t'($urandom);
        mawb_val = $urandom;
        if (is_mdu) begin
            unit_a = unit_t'(1 << `EX_UNIT_MDU);
            func_a = ($urandom_range(0, 1) == 1) ? F_MULHU : F_MUL;
            name   = $sformatf("mul_%0d", idx);
        end else if (kind <= 4) begin
            unit_a = unit_t'(1 << `EX_UNIT_ALU);
            func_a = func_t'($urandom_range(0, 9));
            name   = $sformatf("alu_%0d", idx);
        end else begin
            unit_a = unit_t'(1 << `EX_UNIT_LSU);
            func_a = func_t'($urandom_range(12, 14));
            if ($urandom_range(0, 1) == 1) begin
                op1_a[1:0] = 2'b00;     // Aligned half the time
            end
            name = $sformatf("lsu_%0d", idx);
        end
        op1_b  = op1_a;
        op2_b  = op2_a;
        unit_b = unit_a;
        func_b = func_a;
        fwd_b  = fwd_a;
        if (!is_mdu && ($urandom_range(0, 7) == 0)) begin
            name = {name, "_dscr"};
            case ($urandom_range(0, 2))
                0:       op1_b = op1_b ^ (word_t'(1) << $urandom_range(0, `EX_XLEN - 1));
                1:       op2_b = op2_b ^ (word_t'(1) << $urandom_range(0, `EX_XLEN - 1));
                default: unit_b = unit_a[`EX_UNIT_ALU] ? unit_t'(1 << `EX_UNIT_LSU)
                                                       : unit_t'(1 << `EX_UNIT_ALU);
            endcase
        end

        test_errors = 0;
        mul_steps   = 0;
        done        = 1'b0;
        while (!done) begin
            run_cycle(name);
            if (is_mdu) begin
                done = !seen_stall && !stall;   // Product taken into EX/MA
            end else begin
                done = flush || !stall;
            end
            if (!done) begin
                stall = ($urandom_range(0, 7) == 0);
                if (!is_mdu) begin
                    flush = ($urandom_range(0, 15) == 0);
                end
            end
        end
        report_test(name);
    endtask

    initial begin
        seed_out  = $urandom(SEED);
        arst_n    = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        op1_a     = '0;
        op2_a     = '0;
        unit_a    = '0;
        func_a    = F_ADD;
        fwd_a     = '0;
        op1_b     = '0;
        op2_b     = '0;
        unit_b    = '0;
        func_b    = F_ADD;
        fwd_b     = '0;
        rd        = '0;
        mawb_val  = '0;
        m_val     = '0;
        m_rd      = '0;
        m_unit    = '0;
        m_func    = F_ADD;
        m_imiscon = IMISCON_FREE;
        m_neq     = 1'b0;
        mul_steps = 0;
        mul_op1   = '0;
        mul_op2   = '0;
        pass_count = 0;
        fail_count = 0;

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_errors = 0;
        check_exma("reset");
        check_bit("reset", "stall_o", 1'b0, stall_o);
        check_bit("reset", "lsu_approve_o", 1'b0, lsu_approve_o);
        report_test("reset");

        for (int i = 0; i < NUM_INSTR; i++) begin
            run_test(i);
        end

        $display("Tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/ex_pkg.sv
src/ex_mdu.sv
src/ex_lane.sv
src/ex_exma_reg.sv
src/ex_stage.sv
testbench/ex_stage_tb.sv
